/* cobs_pkg.sv */
// shared COBS decoder types and byte constants, imported by the decoder modules and testbench
package cobs_pkg;

    // frame delimiter on the encoded stream
    localparam logic [7:0] code_delim = 8'h00;

    // code for an empty segment, zero follows directly
    localparam logic [7:0] code_one = 8'h01;

    // longest segment code, no implicit zero after it
    localparam logic [7:0] code_max = 8'hff;

    // encoded byte as it arrives from the source
    typedef struct packed {
        logic [7:0] data;
        // frame end marked by the source
        logic       last;
        // error reported by the source
        logic       user;
    } cobs_in_beat_t;

    // decoded byte towards the sink
    typedef struct packed {
        logic [7:0] data;
        // final byte of the decoded frame
        logic       last;
        // frame was malformed, only valid with last
        logic       err;
    } cobs_out_beat_t;

    // decoder position within a frame
    // idle waits for the first code byte
    // segment takes data bytes of the current group
    // next_segment expects a code byte or a delimiter
    typedef enum logic [1:0] {
        st_idle         = 2'd0,
        st_segment      = 2'd1,
        st_next_segment = 2'd2
    } cobs_state_t;

endpackage

/* axis_skid_buffer.sv */
// registered valid/ready stage with one overflow entry, payload type set per instance
module axis_skid_buffer #(
    parameter type beat_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst,
    input  beat_t in_beat,
    input  logic  in_valid,
    output logic  in_ready,
    output beat_t out_beat,
    output logic  out_valid,
    input  logic  out_ready
);

    // main entry drives the output
    beat_t main_beat;
    logic  main_valid;
    // overflow entry catches the beat accepted while main stalls
    beat_t skid_beat;
    logic  skid_valid;
    logic  ready_reg;
    logic  ready_next;
    logic  main_load_in;
    logic  main_load_skid;
    logic  skid_load;

    assign in_ready  = ready_reg;
    assign out_beat  = main_beat;
    assign out_valid = main_valid;

    // ready for next cycle: output drains now, or nothing is stored
    assign ready_next = out_ready || (!skid_valid && !main_valid);

    always_comb begin
        main_load_in   = 1'b0;
        main_load_skid = 1'b0;
        skid_load      = 1'b0;
        if (ready_reg) begin
            // overflow is empty whenever ready is high
            if (out_ready || !main_valid) begin
                main_load_in = 1'b1;
            end else begin
                skid_load = 1'b1;
            end
        end else if (out_ready) begin
            // input closed, refill main from overflow
            main_load_skid = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            ready_reg <= ready_next;
            if (main_load_in) begin
                main_valid <= in_valid;
            end else if (main_load_skid) begin
                main_valid <= skid_valid;
                skid_valid <= 1'b0;
            end
            if (skid_load) begin
                skid_valid <= in_valid;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (main_load_in) begin
            main_beat <= in_beat;
        end else if (main_load_skid) begin
            main_beat <= skid_beat;
        end
        if (skid_load) begin
            skid_beat <= in_beat;
        end
    end

    // stalled beat stays put until the sink takes it
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* cobs_segment_counter.sv */
// remaining-length counter for the current COBS segment, loaded by the decoder on each code byte
module cobs_segment_counter
    import cobs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       seg_load,
    input  logic [7:0] seg_code,
    input  logic       seg_dec,
    output logic       seg_end,
    output logic       suppress_zero
);

    // data bytes still due in this segment
    logic [7:0] count;
    // segment was the full 254-byte kind
    logic       suppress;

    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= 8'd0;
            suppress <= 1'b0;
        end else if (seg_load) begin
            // code byte counts itself, so one less data byte
            count    <= seg_code - 8'd1;
            suppress <= (seg_code == code_max);
        end else if (seg_dec) begin
            count <= count - 8'd1;
        end
    end

    // current data byte is the last of the segment
    assign seg_end       = (count == 8'd1);
    assign suppress_zero = suppress;

    // decoder only takes data bytes that a code byte announced
    assert property (@(posedge clk) disable iff (rst)
        seg_dec |-> count != 8'd0);

    // code and data bytes never arrive in the same cycle
    assert property (@(posedge clk) disable iff (rst)
        !(seg_load && seg_dec));

endmodule

/* cobs_decode_fsm.sv */
// COBS segment state machine, turns encoded bytes into decoded beats through a one-byte hold
module cobs_decode_fsm
    import cobs_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  cobs_in_beat_t  in_beat,
    input  logic           in_valid,
    output logic           in_ready,
    output cobs_out_beat_t dec_beat,
    output logic           dec_valid,
    input  logic           dec_ready,
    output logic           seg_load,
    output logic           seg_dec,
    output logic [7:0]     seg_code,
    input  logic           seg_end,
    input  logic           suppress_zero
);

    cobs_state_t state;
    cobs_state_t state_next;
    // decoded byte waiting until we know whether it ends the frame
    logic [7:0]  hold_data;
    logic [7:0]  hold_data_next;
    logic        hold_valid;
    logic        hold_valid_next;
    logic        in_fire;
    logic [7:0]  err_data;
    logic        bad_seg;
    logic        bad_next;

    // every accepted byte may emit a beat, so input follows output ready
    // idle with a held byte spends one cycle closing the frame first
    assign in_ready = dec_ready && !(state == st_idle && hold_valid);
    assign in_fire  = in_valid && in_ready;
    assign seg_code = in_beat.data;

    // error beat carries the pending byte, or zero when nothing is held
    assign err_data = hold_valid ? hold_data : 8'h00;

    // zero inside a group, early last, or source error
    assign bad_seg = (in_beat.data == code_delim) || in_beat.user ||
                     (in_beat.last && !seg_end);
    // at a code position only a final code 1 may carry last
    assign bad_next = in_beat.user || (in_beat.last && in_beat.data != code_one);

    always_comb begin
        state_next      = state;
        hold_data_next  = hold_data;
        hold_valid_next = hold_valid;
        dec_beat        = '{data: hold_data, last: 1'b0, err: 1'b0};
        dec_valid       = 1'b0;
        seg_load        = 1'b0;
        seg_dec         = 1'b0;
        case (state)
            st_idle: begin
                if (hold_valid) begin
                    // final byte of the previous frame
                    dec_valid     = 1'b1;
                    dec_beat.last = 1'b1;
                    if (dec_ready) begin
                        hold_valid_next = 1'b0;
                    end
                end else if (in_fire && in_beat.data != code_delim) begin
                    if (in_beat.last || in_beat.user) begin
                        // lone code byte is not a frame
                        dec_valid = 1'b1;
                        dec_beat  = '{data: 8'h00, last: 1'b1, err: 1'b1};
                    end else begin
                        seg_load   = 1'b1;
                        state_next = (in_beat.data == code_one) ? st_next_segment : st_segment;
                    end
                end
                // zeros between frames fall through here
            end
            st_segment: begin
                if (in_fire) begin
                    seg_dec         = 1'b1;
                    hold_data_next  = in_beat.data;
                    hold_valid_next = 1'b1;
                    dec_valid       = hold_valid;
                    if (bad_seg) begin
                        // faulty byte is dropped, frame closes with err
                        hold_valid_next = 1'b0;
                        dec_valid       = 1'b1;
                        dec_beat        = '{data: err_data, last: 1'b1, err: 1'b1};
                        state_next      = st_idle;
                    end else if (in_beat.last) begin
                        // clean end, idle releases this byte with last
                        state_next = st_idle;
                    end else if (seg_end) begin
                        state_next = st_next_segment;
                    end
                end
            end
            st_next_segment: begin
                if (in_fire) begin
                    // implicit zero between groups
                    // after a 255 group the last data byte stays held instead
                    if (!suppress_zero) begin
                        hold_data_next  = 8'h00;
                        hold_valid_next = 1'b1;
                        dec_valid       = hold_valid;
                    end
                    if (in_beat.data == code_delim) begin
                        // delimiter drops the trailing zero and closes the frame
                        hold_valid_next = 1'b0;
                        dec_valid       = hold_valid || in_beat.user;
                        dec_beat        = '{data: err_data, last: 1'b1, err: in_beat.user};
                        state_next      = st_idle;
                    end else if (bad_next) begin
                        hold_valid_next = 1'b0;
                        dec_valid       = 1'b1;
                        dec_beat        = '{data: err_data, last: 1'b1, err: 1'b1};
                        state_next      = st_idle;
                    end else if (in_beat.last) begin
                        // final code 1, idle releases the held byte with last
                        state_next = st_idle;
                    end else begin
                        seg_load   = 1'b1;
                        state_next = (in_beat.data == code_one) ? st_next_segment : st_segment;
                    end
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            hold_valid <= 1'b0;
        end else begin
            state      <= state_next;
            hold_valid <= hold_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        hold_data <= hold_data_next;
    end

    // state never leaves the three decoder states
    assert property (@(posedge clk) disable iff (rst)
        state inside {st_idle, st_segment, st_next_segment});

endmodule

/* cobs_decode_top.sv */
// COBS byte-stream decoder top level, buffered valid/ready ports on both sides
module cobs_decode_top
    import cobs_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  cobs_in_beat_t  s_beat,
    input  logic           s_valid,
    output logic           s_ready,
    output cobs_out_beat_t m_beat,
    output logic           m_valid,
    input  logic           m_ready
);

    // encoded stream after the input buffer
    cobs_in_beat_t  in_beat;
    logic           in_valid;
    logic           in_ready;
    // decoded stream into the output buffer
    cobs_out_beat_t dec_beat;
    logic           dec_valid;
    logic           dec_ready;
    // segment counter strobes and status
    logic           seg_load;
    logic           seg_dec;
    logic [7:0]     seg_code;
    logic           seg_end;
    logic           suppress_zero;

    axis_skid_buffer #(.beat_t(cobs_in_beat_t)) in_buf (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (s_beat),
        .in_valid  (s_valid),
        .in_ready  (s_ready),
        .out_beat  (in_beat),
        .out_valid (in_valid),
        .out_ready (in_ready)
    );

    cobs_decode_fsm fsm (
        .clk           (clk),
        .rst           (rst),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .dec_beat      (dec_beat),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .seg_load      (seg_load),
        .seg_dec       (seg_dec),
        .seg_code      (seg_code),
        .seg_end       (seg_end),
        .suppress_zero (suppress_zero)
    );

    cobs_segment_counter seg_cnt (
        .clk           (clk),
        .rst           (rst),
        .seg_load      (seg_load),
        .seg_code      (seg_code),
        .seg_dec       (seg_dec),
        .seg_end       (seg_end),
        .suppress_zero (suppress_zero)
    );

    axis_skid_buffer #(.beat_t(cobs_out_beat_t)) out_buf (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (dec_beat),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .out_beat  (m_beat),
        .out_valid (m_valid),
        .out_ready (m_ready)
    );

endmodule

/* tb_cobs_decode.sv */
// self-checking testbench for the COBS decoder, run by Verilator through the build script
module tb_cobs_decode
    import cobs_pkg::*;
();

    logic           clk = 1'b0;
    logic           rst = 1'b1;
    cobs_in_beat_t  s_beat = '0;
    logic           s_valid = 1'b0;
    logic           s_ready;
    cobs_out_beat_t m_beat;
    logic           m_valid;
    logic           m_ready = 1'b0;

    // lcg state for payloads, lengths and sink stalls
    logic [31:0]    lcg_state = 32'hc3ea;
    // current payload and its encoding, map_q gives the payload index of each data byte
    logic [7:0]     pay_q[$];
    logic [7:0]     enc_q[$];
    int             map_q[$];
    // whole input stream and the decoded beats it must produce
    cobs_in_beat_t  in_q[$];
    cobs_out_beat_t exp_q[$];
    // precomputed sink ready pattern for the back-pressure pass
    bit             ready_q[$];
    int             sent = 0;
    int             total = 0;
    int             pass1_len = 0;
    int             exp_idx = 0;
    int             cycles = 0;
    int             limit = 0;
    int             checks = 0;
    int             errors = 0;

    cobs_decode_top uut (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int r;
        // low bits of an lcg are weak, take the upper ones
        r = int'(rand_next() >> 8);
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic logic [7:0] rand_byte(input int zero_pct);
        if (rand_range(0, 99) < zero_pct) begin
            return 8'h00;
        end
        return 8'(rand_range(1, 255));
    endfunction

    // reference COBS encoder, one open group at a time
    function automatic void encode_payload();
        int code_idx;
        int i;
        enc_q.delete();
        map_q.delete();
        code_idx = 0;
        enc_q.push_back(8'h01);
        map_q.push_back(-1);
        for (i = 0; i < pay_q.size(); i++) begin
            if (pay_q[i] == 8'h00) begin
                // zero closes the group, the code stands for it
                code_idx = enc_q.size();
                enc_q.push_back(8'h01);
                map_q.push_back(-1);
            end else begin
                enc_q.push_back(pay_q[i]);
                map_q.push_back(i);
                enc_q[code_idx] = enc_q[code_idx] + 8'd1;
                if (enc_q[code_idx] == code_max) begin
                    // full group, next code starts without an implied zero
                    code_idx = enc_q.size();
                    enc_q.push_back(8'h01);
                    map_q.push_back(-1);
                end
            end
        end
    endfunction

    // a data byte that still has a data byte after it in the same group
    function automatic bit fault_ok(input int pos, input int fault);
        if (map_q[pos] < 0) begin
            return 1'b0;
        end
        if (fault == 0) begin
            return 1'b1;
        end
        return (pos + 1 < map_q.size()) && (map_q[pos + 1] >= 0);
    endfunction

    task automatic add_bytes(input int len, input int zero_pct);
        int i;
        for (i = 0; i < len; i++) begin
            pay_q.push_back(rand_byte(zero_pct));
        end
    endtask

    // first n payload bytes, closed by last, a lone zero beat when n is 0
    task automatic expect_prefix(input int n, input logic err);
        int i;
        if (n == 0) begin
            exp_q.push_back(cobs_out_beat_t'{data: 8'h00, last: 1'b1, err: err});
        end
        for (i = 0; i < n; i++) begin
            exp_q.push_back(cobs_out_beat_t'{data: pay_q[i], last: (i == n - 1),
                                             err: err && (i == n - 1)});
        end
    endtask

    task automatic queue_good(input bit delim, input int lead);
        int i;
        encode_payload();
        for (i = 0; i < lead; i++) begin
            in_q.push_back(cobs_in_beat_t'{data: 8'h00, last: 1'b0, user: 1'b0});
        end
        for (i = 0; i < enc_q.size(); i++) begin
            in_q.push_back(cobs_in_beat_t'{data: enc_q[i],
                                           last: !delim && (i == enc_q.size() - 1),
                                           user: 1'b0});
        end
        if (delim) begin
            in_q.push_back(cobs_in_beat_t'{data: code_delim, last: 1'b0, user: 1'b0});
        end
        expect_prefix(pay_q.size(), 1'b0);
    endtask

    // fault 0 zero in a group, 1 early last, 2 source error on the final byte
    task automatic queue_bad(input int fault);
        int i;
        int pos;
        int tries;
        pay_q.delete();
        add_bytes(rand_range(4, 30), 20);
        // two nonzero bytes up front so a fault position always exists
        pay_q[0] = 8'(rand_range(1, 255));
        pay_q[1] = 8'(rand_range(1, 255));
        encode_payload();
        if (fault == 2) begin
            for (i = 0; i < enc_q.size(); i++) begin
                in_q.push_back(cobs_in_beat_t'{data: enc_q[i], last: (i == enc_q.size() - 1),
                                               user: (i == enc_q.size() - 1)});
            end
            expect_prefix(pay_q.size() - 1, 1'b1);
        end else begin
            pos = rand_range(0, enc_q.size() - 1);
            for (tries = 0; tries < enc_q.size() && !fault_ok(pos, fault); tries++) begin
                pos = (pos + 1) % enc_q.size();
            end
            for (i = 0; i < pos; i++) begin
                in_q.push_back(cobs_in_beat_t'{data: enc_q[i], last: 1'b0, user: 1'b0});
            end
            in_q.push_back(cobs_in_beat_t'{data: (fault == 0) ? 8'h00 : enc_q[pos],
                                           last: (fault == 1), user: 1'b0});
            // the faulty byte itself is not part of the output
            expect_prefix(map_q[pos], 1'b1);
        end
    endtask

    task automatic queue_pass();
        int k;
        // short frames with zeros, closed by last
        for (k = 0; k < 12; k++) begin
            pay_q.delete();
            add_bytes(rand_range(1, 40), 20);
            queue_good(1'b0, 0);
        end
        // long nonzero runs around the 255 code
        pay_q.delete();
        add_bytes(300, 0);
        queue_good(1'b0, 0);
        pay_q.delete();
        add_bytes(254, 0);
        pay_q.push_back(8'h00);
        add_bytes(10, 20);
        queue_good(1'b0, 0);
        pay_q.delete();
        add_bytes(254, 0);
        queue_good(1'b0, 0);
        // same full group, closed by a delimiter
        pay_q.delete();
        add_bytes(254, 0);
        queue_good(1'b1, 1);
        pay_q.delete();
        add_bytes(3, 20);
        add_bytes(260, 0);
        queue_good(1'b1, 2);
        // delimiter frames with idle zeros in front
        for (k = 0; k < 6; k++) begin
            pay_q.delete();
            add_bytes(rand_range(1, 40), 20);
            queue_good(1'b1, rand_range(0, 3));
        end
        // each malformed frame is followed by a clean one
        for (k = 0; k < 6; k++) begin
            queue_bad(k % 3);
            pay_q.delete();
            add_bytes(rand_range(1, 40), 20);
            queue_good(1'b0, 0);
        end
    endtask

    task automatic compare_value(input logic [9:0] got, input logic [9:0] want,
                                 input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error at time %0t: %s got %03h expected %03h", $time, what, got, want);
        end
    endtask

    // reset, source and sink, all on the rising edge
    always @(posedge clk) begin
        cycles <= cycles + 1;
        rst    <= (cycles < 2);
        if (!rst) begin
            if (!s_valid || s_ready) begin
                if (sent < total) begin
                    s_beat  <= in_q[sent];
                    s_valid <= 1'b1;
                    sent    <= sent + 1;
                end else begin
                    s_valid <= 1'b0;
                end
            end
            // second pass runs with a stalling sink
            m_ready <= (sent < pass1_len) ? 1'b1 : ready_q[cycles];
        end
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d beats seen, %0d errors",
                     cycles, exp_idx, exp_q.size(), errors);
            $display("TB FAILED");
            $finish;
        end
    end

    // compare every output transfer with the next expected beat
    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            if (exp_idx >= exp_q.size()) begin
                errors++;
                $display("output beat %03h at time %0t arrived with no decoded frame pending",
                         m_beat, $time);
            end else begin
                compare_value(m_beat, exp_q[exp_idx], $sformatf("output beat %0d", exp_idx));
                exp_idx++;
            end
        end
    end

    initial begin
        int i;
        queue_pass();
        pass1_len = in_q.size();
        queue_pass();
        total = in_q.size();
        limit = 4 * total + 200;
        for (i = 0; i < limit; i++) begin
            ready_q.push_back(rand_range(0, 1) == 1);
        end
        while (sent < total || exp_idx < exp_q.size()) begin
            @(posedge clk);
        end
        // a few more cycles to catch stray beats
        repeat (20) @(posedge clk);
        $display("beats checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
cobs_pkg.sv
axis_skid_buffer.sv
cobs_segment_counter.sv
cobs_decode_fsm.sv
cobs_decode_top.sv
tb_cobs_decode.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the COBS decoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_cobs_decode -f build.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0
